//--- compile.f
hdl/resp_trans_pkg.sv
hdl/sync_fifo.sv
hdl/resp_trans_thread.sv
hdl/packet_buffer.sv
hdl/resp_trans_top.sv
bench/resp_trans_tb.sv

//--- run.sh
#!/bin/sh
# build and run the response transmit testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module resp_trans_tb -o resp_trans_sim
out=$(./obj_dir/resp_trans_sim)
echo "$out"
if echo "$out" | grep -qx "all tests passed"; then
    exit 0
else
    exit 1
fi

//--- bench/resp_trans_tb.sv
`timescale 1ns/1ps
// testbench for the response transmit path
// drives random metadata and payload and checks egress headers and slot contents against a model
module resp_trans_tb;

    import resp_trans_pkg::*;

    localparam int RANDOM_PKTS = 24;
    // long read responses of 6 or 7 pieces each
    localparam int BURST_PKTS  = 8;

    logic           clk;
    logic           rst;
    logic           meta_wr;
    net_resp_meta_t meta_din;
    logic           meta_full;
    logic           payload_wr;
    payload_t       payload_din;
    logic           payload_full;
    logic           egress_valid;
    pkt_meta_t      egress_head;
    logic           egress_ready;
    slot_idx_t      rd_slot;
    payload_t       rd_data;
    logic           free_slot;

    // stimulus and reference model
    int unsigned    seed = 32'd11582;
    net_resp_meta_t meta_q[$];
    payload_t       data_q[$];
    pkt_meta_t      exp_head[$];
    int             exp_cnt[$];
    slot_idx_t      model_ptr;
    int             burst_first;
    int             n_stim;
    int             total_pieces;
    int             data_idx;
    int             cycle_cnt;
    int             cycle_limit;
    int             n_checks;
    int             n_errors;

    resp_trans_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .meta_wr      (meta_wr),
        .meta_din     (meta_din),
        .meta_full    (meta_full),
        .payload_wr   (payload_wr),
        .payload_din  (payload_din),
        .payload_full (payload_full),
        .egress_valid (egress_valid),
        .egress_head  (egress_head),
        .egress_ready (egress_ready),
        .rd_slot      (rd_slot),
        .rd_data      (rd_data),
        .free_slot    (free_slot)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // lcg step with swapped halves so the low bits suit small ranges
    function automatic int unsigned rand32();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]};
    endfunction

    function automatic payload_t rand_piece();
        payload_t d;
        int w;
        for (w = 0; w < 16; w++) begin
            d[w*32 +: 32] = rand32();
        end
        return d;
    endfunction

    task automatic expect_eq(input string name, input logic [511:0] exp, input logic [511:0] act);
        n_checks++;
        assert (act === exp) else begin
            n_errors++;
            $display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        n_checks++;
        assert (cond) else begin
            n_errors++;
            $display("%s", what);
        end
    endtask

    // one metadata record plus its expected header and payload
    task automatic add_packet(input opcode_t opc, input pkt_len_t len);
        net_resp_meta_t m;
        pkt_meta_t h;
        int pieces;
        int i;
        m = '0;
        m.pkt_length   = len;
        m.sip          = rand32();
        m.dip          = rand32();
        m.smac         = mac_t'({rand32(), rand32()});
        m.dmac         = mac_t'({rand32(), rand32()});
        m.service_type = 3'(rand32());
        m.opcode       = opc;
        m.remote_qpn   = qpn_t'(rand32());
        m.local_qpn    = qpn_t'(rand32());
        meta_q.push_back(m);
        n_stim++;
        // unknown opcodes never reach egress
        if (opc >= OP_READ_RESP_FIRST && opc <= OP_ACKNOWLEDGE) begin
            pieces = (opc == OP_ACKNOWLEDGE) ? 0 : (int'(len) + PIECE_BYTES - 1) / PIECE_BYTES;
            h.pkt_length   = len;
            h.start_slot   = (pieces > 0) ? model_ptr : slot_idx_t'(0);
            h.sip          = m.sip;
            h.dip          = m.dip;
            h.smac         = m.smac;
            h.dmac         = m.dmac;
            h.remote_qpn   = m.remote_qpn;
            h.service_type = m.service_type;
            h.opcode       = opc;
            h.local_qpn    = m.local_qpn;
            // ring pointer moves by the packet's piece count
            model_ptr = slot_idx_t'(int'(model_ptr) + pieces);
            for (i = 0; i < pieces; i++) begin
                data_q.push_back(rand_piece());
            end
            exp_head.push_back(h);
            exp_cnt.push_back(pieces);
            total_pieces += pieces;
        end
    endtask

    task automatic feed_meta();
        int i;
        i = 0;
        while (i < meta_q.size()) begin
            @(posedge clk);
            #10;
            meta_wr = !meta_full;
            if (!meta_full) begin
                meta_din = meta_q[i];
                i++;
            end
        end
        @(posedge clk);
        #10;
        meta_wr = 1'b0;
    endtask

    task automatic feed_payload();
        int i;
        i = 0;
        while (i < data_q.size()) begin
            @(posedge clk);
            #10;
            payload_wr = !payload_full;
            if (!payload_full) begin
                payload_din = data_q[i];
                i++;
            end
        end
        @(posedge clk);
        #10;
        payload_wr = 1'b0;
    endtask

    // header check and random back-pressure before the handshake
    task automatic accept_egress(input int k);
        int stall;
        do begin
            @(posedge clk);
            #5;
        end while (!egress_valid);
        expect_eq("egress_head", 512'(exp_head[k]), 512'(egress_head));
        stall = int'(rand32() % 4);
        repeat (stall) begin
            @(posedge clk);
            #5;
            expect_eq("egress_valid", 512'd1, 512'(egress_valid));
            expect_eq("egress_head", 512'(exp_head[k]), 512'(egress_head));
        end
        #5;
        egress_ready = 1'b1;
        @(posedge clk);
        #10;
        egress_ready = 1'b0;
    endtask

    // one slot per cycle
    // a slot freed at an edge cannot be rewritten before the next one
    task automatic read_slots(input slot_idx_t start, input int n, input logic do_free);
        int i;
        for (i = 0; i < n; i++) begin
            rd_slot   = slot_idx_t'(int'(start) + i);
            free_slot = do_free;
            @(posedge clk);
            #5;
            expect_eq("rd_data", data_q[data_idx], rd_data);
            data_idx++;
            #5;
        end
        free_slot = 1'b0;
    endtask

    // thread stalls on a full buffer so both queues back up
    task automatic wait_full();
        bit seen;
        int i;
        seen = 1'b0;
        for (i = 0; i < 100 && !seen; i++) begin
            @(posedge clk);
            #5;
            expect_eq("egress_valid", 512'd0, 512'(egress_valid));
            seen = meta_full && payload_full;
        end
        expect_true(seen, "metadata and payload queues never filled while the buffer was full");
        #5;
    endtask

    task automatic free_slots(input int n);
        free_slot = 1'b1;
        repeat (n) @(posedge clk);
        #10;
        free_slot = 1'b0;
    endtask

    task automatic drain();
        int k;
        int held;
        bit holding;
        bit released;
        held = 0;
        released = 1'b0;
        for (k = 0; k < exp_head.size(); k++) begin
            holding = (k >= burst_first) && !released;
            accept_egress(k);
            read_slots(exp_head[k].start_slot, exp_cnt[k], !holding);
            if (holding) begin
                held += exp_cnt[k];
                // next packet cannot fit until the held slots return
                if (k + 1 == exp_head.size() || held + exp_cnt[k + 1] > SLOT_NUM) begin
                    if (k + 1 < exp_head.size()) begin
                        wait_full();
                    end
                    free_slots(held);
                    released = 1'b1;
                end
            end
        end
    endtask

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout, run did not complete within %0d cycles", cycle_limit);
        $display("checks run %0d, errors %0d", n_checks, n_errors);
        $display("tests failed");
        $finish;
    end

    initial begin : main_seq
        int i;
        int sel;
        opcode_t opc;
        pkt_len_t len;
        rst          = 1'b1;
        meta_wr      = 1'b0;
        meta_din     = '0;
        payload_wr   = 1'b0;
        payload_din  = '0;
        egress_ready = 1'b0;
        rd_slot      = '0;
        free_slot    = 1'b0;
        model_ptr    = '0;
        n_stim       = 0;
        total_pieces = 0;
        data_idx     = 0;
        cycle_cnt    = 0;
        cycle_limit  = 0;
        n_checks     = 0;
        n_errors     = 0;
        // mixed opcodes with about a quarter at zero length
        for (i = 0; i < RANDOM_PKTS; i++) begin
            sel = int'(rand32() % 8);
            len = (rand32() % 4 == 0) ? pkt_len_t'(0) : pkt_len_t'(rand32() % 401);
            if (sel < 4) begin
                opc = OP_READ_RESP_FIRST + opcode_t'(sel);
            end else if (sel < 6) begin
                opc = OP_ACKNOWLEDGE;
            end else begin
                opc = opcode_t'(rand32() % 13);
            end
            add_packet(opc, len);
        end
        burst_first = exp_head.size();
        for (i = 0; i < BURST_PKTS; i++) begin
            add_packet(OP_READ_RESP_FIRST + opcode_t'(rand32() % 4), pkt_len_t'(321 + rand32() % 80));
        end
        cycle_limit = total_pieces + 20 * n_stim + 200;
        repeat (10) @(posedge clk);
        #10;
        rst = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #5;
            expect_eq("egress_valid", 512'd0, 512'(egress_valid));
            expect_eq("meta_full", 512'd0, 512'(meta_full));
            expect_eq("payload_full", 512'd0, 512'(payload_full));
        end
        #5;
        fork
            feed_meta();
            feed_payload();
            drain();
        join
        // no egress beyond the expected headers
        repeat (20) begin
            @(posedge clk);
            #5;
            expect_eq("egress_valid", 512'd0, 512'(egress_valid));
        end
        $display("checks run %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- hdl/resp_trans_top.sv
`timescale 1ns/1ps
// response transmit path top
// metadata and payload queues feeding the transmit thread and packet buffer
module resp_trans_top (
    input  logic                           clk,
    input  logic                           rst,
    // metadata in
    input  logic                           meta_wr,
    input  resp_trans_pkg::net_resp_meta_t meta_din,
    output logic                           meta_full,
    // payload in
    input  logic                           payload_wr,
    input  resp_trans_pkg::payload_t       payload_din,
    output logic                           payload_full,
    // egress
    output logic                           egress_valid,
    output resp_trans_pkg::pkt_meta_t      egress_head,
    input  logic                           egress_ready,
    // consumer side of the buffer
    input  resp_trans_pkg::slot_idx_t      rd_slot,
    output resp_trans_pkg::payload_t       rd_data,
    input  logic                           free_slot
);

    import resp_trans_pkg::*;

    // queue heads
    logic           meta_rd;
    logic           meta_empty;
    net_resp_meta_t meta_dout;
    logic           payload_rd;
    logic           payload_empty;
    payload_t       payload_dout;

    // insert port
    logic           insert_valid;
    logic           insert_start;
    logic           insert_last;
    piece_cnt_t     insert_total;
    payload_t       insert_data;
    logic           insert_ready;
    logic           insert_resp_valid;
    slot_idx_t      insert_resp_slot;

    sync_fifo #(
        .WIDTH ($bits(net_resp_meta_t)),
        .DEPTH (META_DEPTH)
    ) meta_fifo_i (
        .clk   (clk),
        .rst   (rst),
        .wr    (meta_wr),
        .din   (meta_din),
        .full  (meta_full),
        .rd    (meta_rd),
        .dout  (meta_dout),
        .empty (meta_empty)
    );

    sync_fifo #(
        .WIDTH ($bits(payload_t)),
        .DEPTH (PAYLOAD_DEPTH)
    ) payload_fifo_i (
        .clk   (clk),
        .rst   (rst),
        .wr    (payload_wr),
        .din   (payload_din),
        .full  (payload_full),
        .rd    (payload_rd),
        .dout  (payload_dout),
        .empty (payload_empty)
    );

    resp_trans_thread thread_i (
        .clk               (clk),
        .rst               (rst),
        .meta_rd           (meta_rd),
        .meta_empty        (meta_empty),
        .meta_dout         (meta_dout),
        .payload_rd        (payload_rd),
        .payload_empty     (payload_empty),
        .payload_dout      (payload_dout),
        .insert_valid      (insert_valid),
        .insert_start      (insert_start),
        .insert_last       (insert_last),
        .insert_total      (insert_total),
        .insert_data       (insert_data),
        .insert_ready      (insert_ready),
        .insert_resp_valid (insert_resp_valid),
        .insert_resp_slot  (insert_resp_slot),
        .egress_valid      (egress_valid),
        .egress_head       (egress_head),
        .egress_ready      (egress_ready)
    );

    packet_buffer buffer_i (
        .clk               (clk),
        .rst               (rst),
        .insert_valid      (insert_valid),
        .insert_start      (insert_start),
        .insert_last       (insert_last),
        .insert_total      (insert_total),
        .insert_data       (insert_data),
        .insert_ready      (insert_ready),
        .insert_resp_valid (insert_resp_valid),
        .insert_resp_slot  (insert_resp_slot),
        .rd_slot           (rd_slot),
        .rd_data           (rd_data),
        .free_slot         (free_slot)
    );

endmodule

//--- hdl/packet_buffer.sv
`timescale 1ns/1ps
// slotted packet buffer
// slots handed out in ring order, a packet is admitted only if all its pieces fit
module packet_buffer (
    input  logic                       clk,
    input  logic                       rst,
    // insert port
    input  logic                       insert_valid,
    input  logic                       insert_start,
    input  logic                       insert_last,
    input  resp_trans_pkg::piece_cnt_t insert_total,
    input  resp_trans_pkg::payload_t   insert_data,
    output logic                       insert_ready,
    output logic                       insert_resp_valid,
    output resp_trans_pkg::slot_idx_t  insert_resp_slot,
    // consumer read and release
    input  resp_trans_pkg::slot_idx_t  rd_slot,
    output resp_trans_pkg::payload_t   rd_data,
    input  logic                       free_slot
);

    import resp_trans_pkg::*;

    payload_t                slot_mem [SLOT_NUM];
    slot_idx_t               wr_ptr;
    slot_idx_t               rel_ptr;
    logic [SLOT_NUM_LOG:0]   free_cnt;
    // set between an accepted start and its last piece
    logic                    in_pkt;

    logic                    accept;
    logic                    ring_empty;
    logic                    release_ok;

    // pointers equal with free slots left means nothing is held
    assign ring_empty = (wr_ptr == rel_ptr) && (free_cnt != '0);
    assign release_ok = free_slot && !ring_empty;

    // admission
    always_comb begin
        if (in_pkt) begin
            // room already reserved by the start check
            insert_ready = (free_cnt != '0);
        end else begin
            insert_ready = insert_start && (piece_cnt_t'(free_cnt) >= insert_total);
        end
    end

    assign accept            = insert_valid && insert_ready;
    assign insert_resp_valid = accept;
    assign insert_resp_slot  = wr_ptr;

    // slot storage
    always_ff @(posedge clk) begin
        if (accept) begin
            slot_mem[wr_ptr] <= insert_data;
        end
    end

    // combinational read port
    assign rd_data = slot_mem[rd_slot];

    // ring pointers wrap naturally at SLOT_NUM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr  <= '0;
            rel_ptr <= '0;
            in_pkt  <= 1'b0;
        end else begin
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
                in_pkt <= !insert_last;
            end
            if (release_ok) begin
                rel_ptr <= rel_ptr + 1'b1;
            end
        end
    end

    // free-slot accounting
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            free_cnt <= (SLOT_NUM_LOG + 1)'(SLOT_NUM);
        end else begin
            case ({accept, release_ok})
                2'b10:   free_cnt <= free_cnt - 1'b1;
                2'b01:   free_cnt <= free_cnt + 1'b1;
                // take and give back in one cycle
                default: free_cnt <= free_cnt;
            endcase
        end
    end

endmodule

//--- hdl/resp_trans_thread.sv
`timescale 1ns/1ps
// response transmit thread
// decodes response metadata, stores read payload in the packet buffer, issues egress headers
module resp_trans_thread (
    input  logic                           clk,
    input  logic                           rst,
    // metadata queue
    output logic                           meta_rd,
    input  logic                           meta_empty,
    input  resp_trans_pkg::net_resp_meta_t meta_dout,
    // payload queue
    output logic                           payload_rd,
    input  logic                           payload_empty,
    input  resp_trans_pkg::payload_t       payload_dout,
    // packet buffer insert port
    output logic                           insert_valid,
    output logic                           insert_start,
    output logic                           insert_last,
    output resp_trans_pkg::piece_cnt_t     insert_total,
    output resp_trans_pkg::payload_t       insert_data,
    input  logic                           insert_ready,
    input  logic                           insert_resp_valid,
    input  resp_trans_pkg::slot_idx_t      insert_resp_slot,
    // egress
    output logic                           egress_valid,
    output resp_trans_pkg::pkt_meta_t      egress_head,
    input  logic                           egress_ready
);

    import resp_trans_pkg::*;

    thread_state_t  state;
    thread_state_t  state_nxt;

    // captured record and per-packet bookkeeping
    net_resp_meta_t meta_q;
    piece_cnt_t     piece_left;
    piece_cnt_t     piece_total;
    slot_idx_t      start_slot;

    logic [16:0]    len_round;
    piece_cnt_t     piece_calc;
    logic           is_read_resp;
    logic           is_ack;
    logic           meta_take;
    logic           insert_fire;
    logic           egress_fire;

    // opcode decode on the captured record
    assign is_ack       = (meta_q.opcode == OP_ACKNOWLEDGE);
    assign is_read_resp = (meta_q.opcode == OP_READ_RESP_FIRST)  ||
                          (meta_q.opcode == OP_READ_RESP_MIDDLE) ||
                          (meta_q.opcode == OP_READ_RESP_LAST)   ||
                          (meta_q.opcode == OP_READ_RESP_ONLY);

    // ceil(length / 64)
    // extra bit keeps the rounding add from wrapping
    assign len_round  = {1'b0, meta_q.pkt_length} + 17'(PIECE_BYTES - 1);
    assign piece_calc = piece_cnt_t'(len_round / PIECE_BYTES);

    assign meta_take   = (state == ST_IDLE) && !meta_empty;
    assign insert_fire = insert_valid && insert_ready;
    assign egress_fire = egress_valid && egress_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (!meta_empty) begin
                    state_nxt = ST_JUDGE;
                end
            end
            ST_JUDGE: begin
                // ack and empty reads skip the buffer
                if (is_ack || (is_read_resp && piece_calc == '0)) begin
                    state_nxt = ST_INJECT;
                end else if (is_read_resp) begin
                    state_nxt = ST_INSERT;
                end else begin
                    // unknown opcode is dropped
                    state_nxt = ST_IDLE;
                end
            end
            ST_INSERT: begin
                if (insert_fire && insert_last) begin
                    state_nxt = ST_INJECT;
                end
            end
            ST_INJECT: begin
                if (egress_fire) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    // record capture on the pop
    always_ff @(posedge clk) begin
        if (meta_take) begin
            meta_q <= meta_dout;
        end
    end

    // piece counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            piece_left  <= '0;
            piece_total <= '0;
        end else if (state == ST_JUDGE) begin
            piece_left  <= piece_calc;
            piece_total <= piece_calc;
        end else if (insert_fire) begin
            piece_left  <= piece_left - 1'b1;
        end
    end

    // first slot of the packet
    // cleared in judge so payload-free packets carry zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_slot <= '0;
        end else if (state == ST_JUDGE) begin
            start_slot <= '0;
        end else if (insert_resp_valid && insert_start) begin
            start_slot <= insert_resp_slot;
        end
    end

    assign meta_rd    = meta_take;
    // pop payload together with the accepted piece
    assign payload_rd = insert_fire;

    // insert port
    assign insert_valid = (state == ST_INSERT) && !payload_empty;
    assign insert_start = (piece_left == piece_total);
    assign insert_last  = (piece_left == piece_cnt_t'(1));
    assign insert_total = piece_total;
    assign insert_data  = payload_dout;

    // egress header straight from the held record
    assign egress_valid = (state == ST_INJECT);

    always_comb begin
        egress_head.pkt_length   = meta_q.pkt_length;
        egress_head.start_slot   = start_slot;
        egress_head.sip          = meta_q.sip;
        egress_head.dip          = meta_q.dip;
        egress_head.smac         = meta_q.smac;
        egress_head.dmac         = meta_q.dmac;
        egress_head.remote_qpn   = meta_q.remote_qpn;
        egress_head.service_type = meta_q.service_type;
        egress_head.opcode       = meta_q.opcode;
        egress_head.local_qpn    = meta_q.local_qpn;
    end

endmodule

//--- hdl/sync_fifo.sv
`timescale 1ns/1ps
// show-ahead synchronous fifo
// head entry sits on dout whenever empty is low
module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wr,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    input  logic             rd,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // writes while full and reads while empty are dropped
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // pointers wrap explicitly so any depth works
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // occupancy
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- hdl/resp_trans_pkg.sv
// response transmit path shared definitions
// widths, opcodes, buffer geometry, metadata and egress header layouts
package resp_trans_pkg;

    // one payload piece is a 512-bit beat
    localparam int PIECE_BYTES   = 64;

    // packet buffer geometry
    // slot count must stay a power of two
    localparam int SLOT_NUM      = 16;
    localparam int SLOT_NUM_LOG  = 4;

    // queue depths
    localparam int META_DEPTH    = 4;
    localparam int PAYLOAD_DEPTH = 8;

    // plain vector types
    typedef logic [511:0]            payload_t;
    typedef logic [SLOT_NUM_LOG-1:0] slot_idx_t;
    typedef logic [7:0]              piece_cnt_t;
    typedef logic [15:0]             pkt_len_t;
    typedef logic [23:0]             qpn_t;
    typedef logic [47:0]             mac_t;
    typedef logic [31:0]             ip_t;
    typedef logic [4:0]              opcode_t;

    // rc transport opcodes
    localparam opcode_t OP_READ_RESP_FIRST  = 5'd13;
    localparam opcode_t OP_READ_RESP_MIDDLE = 5'd14;
    localparam opcode_t OP_READ_RESP_LAST   = 5'd15;
    localparam opcode_t OP_READ_RESP_ONLY   = 5'd16;
    localparam opcode_t OP_ACKNOWLEDGE      = 5'd17;

    // 256-bit metadata record from the receive side
    // msb first, matches the legacy bus offsets
    typedef struct packed {
        // upper half of the legacy 32-bit length word
        logic [15:0] rsvd_len;
        pkt_len_t    pkt_length;
        ip_t         sip;
        ip_t         dip;
        mac_t        smac;
        mac_t        dmac;
        logic [2:0]  service_type;
        opcode_t     opcode;
        qpn_t        remote_qpn;
        // gap between the two qpn fields
        logic [7:0]  rsvd_qpn;
        qpn_t        local_qpn;
    } net_resp_meta_t;

    // egress header handed to the transport side
    // start_slot points at the first payload piece in the buffer
    typedef struct packed {
        pkt_len_t    pkt_length;
        slot_idx_t   start_slot;
        ip_t         sip;
        ip_t         dip;
        mac_t        smac;
        mac_t        dmac;
        qpn_t        remote_qpn;
        logic [2:0]  service_type;
        opcode_t     opcode;
        qpn_t        local_qpn;
    } pkt_meta_t;

    // transmit thread states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_JUDGE,
        ST_INSERT,
        ST_INJECT
    } thread_state_t;

endpackage
